/* Makefile */
# Verilator flow for the hybrid BIST controller

VERILATOR  ?= verilator
FILELIST   ?= hybrid_bist.f
TB_TOP     ?= tb_hybrid_bist
RTL_TOP    ?= hybrid_bist
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing -j 0
PASS_MSG   ?= Simulation finished: PASS
RTL_SRCS   ?= $(shell grep '^design/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* design/bist_cfg_pkg.sv */
// geometry fixed at 8 lanes, accumulator depth equals lane count, widths must stay powers of two
`default_nettype none

package bist_cfg_pkg;

    localparam int ARRAY_SIZE = 8;           // lanes, also accumulator rows
    localparam int WEIGHT_W   = 8;
    localparam int ACT_W      = 8;

    // full product plus growth from summing ARRAY_SIZE terms
    localparam int PSUM_W = WEIGHT_W + ACT_W + $clog2(ARRAY_SIZE);
    localparam int ADDR_W = $clog2(ARRAY_SIZE);

    localparam int MBIST_PATTERNS = 8;       // memory test data backgrounds
    localparam int SA_PATTERNS    = 12;      // stuck-at vectors held in the eNVM

    localparam int PAT_IDX_W = $clog2((MBIST_PATTERNS > SA_PATTERNS) ?
                                      MBIST_PATTERNS : SA_PATTERNS);

    typedef logic [PSUM_W-1:0] psum_t;

    // lane 0 sits in the low bits
    typedef logic [ARRAY_SIZE-1:0][PSUM_W-1:0] psum_row_t;

    typedef logic [ARRAY_SIZE-1:0] lane_mask_t;

endpackage

`default_nettype wire

/* design/bist_check_if.sv */
// no clock inside; load and compare strobes are sampled by the comparator's own clock
`timescale 1ns/1ps
`default_nettype none

interface bist_check_if;
    import bist_cfg_pkg::*;
    import bist_ctrl_pkg::*;

    logic       load_exp;     // latch expected value this cycle
    exp_src_t   exp_src;
    logic       compare_en;   // read data is valid for checking
    logic       mismatch;     // any lane differs
    lane_mask_t lanes;        // per-lane mismatch, zero when not comparing

    modport ctrl (
        output load_exp, exp_src, compare_en,
        input  mismatch
    );

    modport chk (
        input  load_exp, exp_src, compare_en,
        output mismatch, lanes
    );

endinterface

`default_nettype wire

/* design/bist_ctrl_pkg.sv */
// state codes are 4 bits wide; values 11 to 15 are unused and fall back to IDLE
`default_nettype none

package bist_ctrl_pkg;

    typedef enum logic [3:0] {
        IDLE       = 4'd0,
        MB_START   = 4'd1,
        MB_WRITE   = 4'd2,
        MB_READ    = 4'd3,
        MB_CHECK   = 4'd4,
        SA_START   = 4'd5,
        SA_SHIFT   = 4'd6,
        SA_CAPTURE = 4'd7,
        SA_CHECK   = 4'd8,
        DONE_PASS  = 4'd9,
        DONE_FAIL  = 4'd10
    } bist_state_t;

    // which value the comparator latches as expected
    typedef enum logic {
        EXP_PATTERN = 1'b0,   // memory test generator
        EXP_ENVM    = 1'b1    // golden answer from the eNVM
    } exp_src_t;

endpackage

`default_nettype wire

/* design/bist_sequencer.sv */
// start is honoured only in IDLE with test_mode high; no back-pressure from array or RAM
`timescale 1ns/1ps
`default_nettype none

module bist_sequencer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start,
    input  logic                                 test_mode,
    input  logic                                 bist_mode,      // 0 memory, 1 scan
    input  logic [bist_cfg_pkg::WEIGHT_W-1:0]    envm_weight,
    input  logic [bist_cfg_pkg::ACT_W-1:0]       envm_activation,
    input  bist_cfg_pkg::psum_t                  pattern,
    bist_check_if.ctrl                           ctrl,
    output logic [bist_cfg_pkg::PAT_IDX_W-1:0]   pattern_idx,
    output logic                                 clear,
    output logic [bist_cfg_pkg::PAT_IDX_W-1:0]   test_counter,
    output logic                                 scan_en,
    output logic [bist_cfg_pkg::WEIGHT_W-1:0]    weight_to_bisr,
    output logic                                 weight_valid,
    output logic                                 weight_start,
    output logic [bist_cfg_pkg::ACT_W-1:0]       activation_to_buffer,
    output logic                                 activation_valid,
    output logic                                 acc_wr_en,
    output logic [bist_cfg_pkg::ADDR_W-1:0]      acc_wr_addr,
    output bist_cfg_pkg::psum_row_t              acc_wr_data,
    output logic                                 acc_test_mode,
    output logic [bist_cfg_pkg::ADDR_W-1:0]      acc_rd_addr,
    output logic                                 test_done,
    output logic                                 test_pass
);
    import bist_cfg_pkg::*;
    import bist_ctrl_pkg::*;

    bist_state_t state, next_state;

    logic [PAT_IDX_W-1:0] pat_cnt;    // pattern or vector index
    logic [ADDR_W-1:0]    addr_cnt;   // accumulator row

    logic start_ok;
    logic last_addr;
    logic last_mb;
    logic last_sa;

    assign start_ok  = start && test_mode && (state == IDLE);
    assign last_addr = (addr_cnt == ADDR_W'(ARRAY_SIZE - 1));
    assign last_mb   = (pat_cnt == PAT_IDX_W'(MBIST_PATTERNS - 1));
    assign last_sa   = (pat_cnt == PAT_IDX_W'(SA_PATTERNS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start_ok) begin
                    next_state = bist_mode ? SA_START : MB_START;
                end
            end
            MB_START: next_state = MB_WRITE;
            MB_WRITE: begin
                if (last_addr) begin
                    next_state = MB_READ;   // whole row set written, read it back
                end
            end
            MB_READ:  next_state = MB_CHECK;
            MB_CHECK: begin
                if (ctrl.mismatch) begin
                    next_state = DONE_FAIL;
                end else if (last_addr) begin
                    next_state = last_mb ? DONE_PASS : MB_WRITE;
                end else begin
                    next_state = MB_READ;
                end
            end
            SA_START:   next_state = SA_SHIFT;
            SA_SHIFT:   next_state = SA_CAPTURE;
            SA_CAPTURE: next_state = SA_CHECK;
            SA_CHECK: begin
                if (ctrl.mismatch) begin
                    next_state = DONE_FAIL;
                end else if (last_sa) begin
                    next_state = DONE_PASS;
                end else begin
                    next_state = SA_SHIFT;
                end
            end
            DONE_PASS, DONE_FAIL: next_state = IDLE;   // single-cycle done
            default:              next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pat_cnt  <= '0;
            addr_cnt <= '0;
        end else if (start_ok) begin
            pat_cnt  <= '0;
            addr_cnt <= '0;
        end else begin
            case (state)
                MB_WRITE: addr_cnt <= last_addr ? '0 : addr_cnt + 1'b1;
                MB_CHECK: begin
                    if (!ctrl.mismatch) begin
                        if (last_addr) begin
                            addr_cnt <= '0;
                            if (!last_mb) begin
                                pat_cnt <= pat_cnt + 1'b1;   // next background
                            end
                        end else begin
                            addr_cnt <= addr_cnt + 1'b1;
                        end
                    end
                end
                SA_CHECK: begin
                    if (!ctrl.mismatch && !last_sa) begin
                        pat_cnt <= pat_cnt + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    assign clear        = start_ok;
    assign pattern_idx  = pat_cnt;
    assign test_counter = pat_cnt;   // eNVM vector select
    assign acc_wr_addr  = addr_cnt;
    assign acc_wr_data  = {ARRAY_SIZE{pattern}};   // same data in every lane

    always_comb begin
        scan_en              = 1'b0;
        weight_to_bisr       = '0;
        weight_valid         = 1'b0;
        weight_start         = 1'b0;
        activation_to_buffer = '0;
        activation_valid     = 1'b0;
        acc_wr_en            = 1'b0;
        acc_test_mode        = 1'b0;
        acc_rd_addr          = addr_cnt;
        test_done            = 1'b0;
        test_pass            = 1'b0;
        ctrl.load_exp        = 1'b0;
        ctrl.exp_src         = EXP_PATTERN;
        ctrl.compare_en      = 1'b0;
        case (state)
            MB_WRITE: begin
                acc_wr_en     = 1'b1;
                acc_test_mode = 1'b1;
            end
            MB_READ: begin
                acc_test_mode = 1'b1;
                ctrl.load_exp = 1'b1;   // generator value for this background
            end
            MB_CHECK: begin
                acc_test_mode   = 1'b1;
                ctrl.compare_en = 1'b1;
            end
            SA_START: weight_start = 1'b1;
            SA_SHIFT: begin
                scan_en              = 1'b1;
                acc_test_mode        = 1'b1;
                weight_to_bisr       = envm_weight;
                weight_valid         = 1'b1;
                activation_to_buffer = envm_activation;
                activation_valid     = 1'b1;
                ctrl.load_exp        = 1'b1;
                ctrl.exp_src         = EXP_ENVM;
            end
            SA_CAPTURE: begin
                acc_test_mode = 1'b1;
                acc_rd_addr   = '0;     // array result lands in row 0
            end
            SA_CHECK: begin
                acc_test_mode   = 1'b1;
                acc_rd_addr     = '0;
                ctrl.compare_en = 1'b1;
            end
            DONE_PASS: begin
                test_done = 1'b1;
                test_pass = 1'b1;
            end
            DONE_FAIL: test_done = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/hybrid_bist.sv */
// accumulator read is assumed registered, one cycle; fail_lanes holds until the next start
`timescale 1ns/1ps
`default_nettype none

module hybrid_bist (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 start,
    input  logic                                 test_mode,
    input  logic                                 bist_mode,     // 0 memory, 1 scan
    input  logic [bist_cfg_pkg::WEIGHT_W-1:0]    envm_weight,
    input  logic [bist_cfg_pkg::ACT_W-1:0]       envm_activation,
    input  bist_cfg_pkg::psum_t                  envm_answer,
    output logic [bist_cfg_pkg::PAT_IDX_W-1:0]   test_counter,
    output logic                                 scan_en,
    output logic [bist_cfg_pkg::WEIGHT_W-1:0]    weight_to_bisr,
    output logic                                 weight_valid,
    output logic                                 weight_start,
    output logic [bist_cfg_pkg::ACT_W-1:0]       activation_to_buffer,
    output logic                                 activation_valid,
    output logic                                 acc_wr_en,
    output logic [bist_cfg_pkg::ADDR_W-1:0]      acc_wr_addr,
    output bist_cfg_pkg::psum_row_t              acc_wr_data,
    output logic                                 acc_test_mode,
    output logic [bist_cfg_pkg::ADDR_W-1:0]      acc_rd_addr,
    input  bist_cfg_pkg::psum_row_t              acc_rd_data,
    output logic                                 test_done,
    output logic                                 test_pass,
    output bist_cfg_pkg::lane_mask_t             fail_lanes
);
    import bist_cfg_pkg::*;

    logic [PAT_IDX_W-1:0] pattern_idx;
    psum_t                pattern;      // memory test background
    logic                 clear;

    bist_check_if chk_bus ();

    bist_sequencer u_seq (
        .clk                  (clk),
        .rst_n                (rst_n),
        .start                (start),
        .test_mode            (test_mode),
        .bist_mode            (bist_mode),
        .envm_weight          (envm_weight),
        .envm_activation      (envm_activation),
        .pattern              (pattern),
        .ctrl                 (chk_bus.ctrl),
        .pattern_idx          (pattern_idx),
        .clear                (clear),
        .test_counter         (test_counter),
        .scan_en              (scan_en),
        .weight_to_bisr       (weight_to_bisr),
        .weight_valid         (weight_valid),
        .weight_start         (weight_start),
        .activation_to_buffer (activation_to_buffer),
        .activation_valid     (activation_valid),
        .acc_wr_en            (acc_wr_en),
        .acc_wr_addr          (acc_wr_addr),
        .acc_wr_data          (acc_wr_data),
        .acc_test_mode        (acc_test_mode),
        .acc_rd_addr          (acc_rd_addr),
        .test_done            (test_done),
        .test_pass            (test_pass)
    );

    mbist_pattern_gen u_pgen (
        .pattern_idx (pattern_idx),
        .pattern     (pattern)
    );

    result_comparator u_cmp (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (clear),
        .pattern     (pattern),
        .envm_answer (envm_answer),
        .rd_data     (acc_rd_data),
        .chk         (chk_bus.chk),
        .fail_lanes  (fail_lanes)
    );

endmodule

`default_nettype wire

/* design/mbist_pattern_gen.sv */
// pure combinational lookup; indices above 7 wrap onto the same eight backgrounds
`timescale 1ns/1ps
`default_nettype none

module mbist_pattern_gen (
    input  logic [bist_cfg_pkg::PAT_IDX_W-1:0] pattern_idx,
    output bist_cfg_pkg::psum_t                pattern
);
    import bist_cfg_pkg::*;

    logic [7:0] seed;

    // stretch an 8-bit seed across the whole lane width
    function automatic psum_t repl(input logic [7:0] s);
        psum_t p;
        for (int i = 0; i < PSUM_W; i++) begin
            p[i] = s[i % 8];
        end
        return p;
    endfunction

    always_comb begin
        case (pattern_idx % MBIST_PATTERNS)
            0:       seed = 8'h00;   // solid zero
            1:       seed = 8'hff;   // solid one
            2:       seed = 8'h55;   // checkerboard
            3:       seed = 8'haa;   // inverse checkerboard
            4:       seed = 8'h0f;
            5:       seed = 8'hf0;
            6:       seed = 8'h33;   // bit pairs
            7:       seed = 8'hcc;
            default: seed = 8'h00;
        endcase
    end

    assign pattern = repl(seed);

endmodule

`default_nettype wire

/* design/result_comparator.sv */
// one expected value is checked against all lanes; only the first failing set is kept
`timescale 1ns/1ps
`default_nettype none

module result_comparator (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  bist_cfg_pkg::psum_t     pattern,
    input  bist_cfg_pkg::psum_t     envm_answer,
    input  bist_cfg_pkg::psum_row_t rd_data,
    bist_check_if.chk               chk,
    output bist_cfg_pkg::lane_mask_t fail_lanes
);
    import bist_cfg_pkg::*;
    import bist_ctrl_pkg::*;

    psum_t exp_q;   // expected lane value

    always_ff @(posedge clk) begin
        if (chk.load_exp) begin
            exp_q <= (chk.exp_src == EXP_ENVM) ? envm_answer : pattern;
        end
    end

    // lane compare, quiet outside the check cycle
    always_comb begin
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            chk.lanes[i] = chk.compare_en && (rd_data[i] != exp_q);
        end
    end

    assign chk.mismatch = |chk.lanes;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fail_lanes <= '0;
        end else if (clear) begin
            fail_lanes <= '0;                       // new test starts clean
        end else if (chk.mismatch && fail_lanes == '0) begin
            fail_lanes <= chk.lanes;               // hold first failure
        end
    end

endmodule

`default_nettype wire

/* hybrid_bist.f */
design/bist_cfg_pkg.sv
design/bist_ctrl_pkg.sv
design/bist_check_if.sv
design/mbist_pattern_gen.sv
design/result_comparator.sv
design/bist_sequencer.sv
design/hybrid_bist.sv
test/tb_models.sv
test/tb_hybrid_bist.sv

/* test/tb_hybrid_bist.sv */
// directed tests; fault lane, bit and vector come from $urandom with a fixed seed
`timescale 1ns/1ps
`default_nettype none

module tb_hybrid_bist;
    import bist_cfg_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;   // tests need about 850 cycles
    localparam int DONE_WAIT      = 300;    // memory test is 193 cycles

    logic clk = 1'b0;
    logic rst_n, start, test_mode, bist_mode;
    logic [WEIGHT_W-1:0] envm_weight, weight_to_bisr;
    logic [ACT_W-1:0] envm_activation, activation_to_buffer;
    logic [PAT_IDX_W-1:0] test_counter, sa_fault_vec;
    logic [ADDR_W-1:0] acc_wr_addr, acc_rd_addr, sa_fault_lane;
    logic scan_en, weight_valid, weight_start, activation_valid, sa_fault_en;
    logic acc_wr_en, acc_test_mode, test_done, test_pass;
    psum_t envm_answer;
    psum_row_t acc_wr_data, acc_rd_data, force_mask;
    lane_mask_t fail_lanes;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_cnt = 0;
    int wr_cnt, rd_cnt, shift_cnt, ws_cnt;   // per-run event counts

    hybrid_bist dut (.*);
    tb_acc_model u_model (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // memory test background built from an 8-bit unit repeated over the lane
    function automatic psum_t exp_pattern(input int idx);
        logic [7:0] unit;
        case (idx % 8)
            0:       unit = 8'b0000_0000;
            1:       unit = 8'b1111_1111;
            2:       unit = 8'b0101_0101;
            3:       unit = 8'b1010_1010;
            4:       unit = 8'b0000_1111;
            5:       unit = 8'b1111_0000;
            6:       unit = 8'b0011_0011;
            default: unit = 8'b1100_1100;
        endcase
        return psum_t'({3{unit}});
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_fail(input string what);
        $display("** Error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failed++;
            $display("test %-14s FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    // called once per cycle at the falling edge while a test runs
    task automatic watch_cycle();
        psum_t exp_p;
        int k;
        int exp_a;
        if (acc_wr_en) begin
            exp_p = exp_pattern(wr_cnt / ARRAY_SIZE);
            if (acc_wr_addr !== ADDR_W'(wr_cnt % ARRAY_SIZE)) begin
                report_mismatch("acc_wr_addr", 32'(acc_wr_addr), 32'(wr_cnt % ARRAY_SIZE));
            end
            for (int i = 0; i < ARRAY_SIZE; i++) begin
                if (acc_wr_data[i] !== exp_p) begin
                    report_mismatch($sformatf("acc_wr_data lane %0d", i),
                                    32'(acc_wr_data[i]), 32'(exp_p));
                end
            end
            wr_cnt++;
        end
        if (!bist_mode && acc_test_mode && !acc_wr_en) begin
            exp_a = (rd_cnt / 2) % ARRAY_SIZE;   // read then check cycle per row
            if (acc_rd_addr !== ADDR_W'(exp_a)) begin
                report_mismatch("acc_rd_addr", 32'(acc_rd_addr), 32'(exp_a));
            end
            rd_cnt++;
        end
        if (weight_start) begin
            ws_cnt++;
        end
        if (scan_en) begin
            k = shift_cnt;
            if (ws_cnt != 1) begin
                report_fail("weight_start did not pulse exactly once before scan_en");
            end
            if (test_counter !== PAT_IDX_W'(k)) begin
                report_mismatch("test_counter", 32'(test_counter), 32'(k));
            end
            if (weight_to_bisr !== WEIGHT_W'(3 * k + 1)) begin
                report_mismatch("weight_to_bisr", 32'(weight_to_bisr), 32'(3 * k + 1));
            end
            if (activation_to_buffer !== ACT_W'(5 * k + 2)) begin
                report_mismatch("activation_to_buffer", 32'(activation_to_buffer),
                                32'(5 * k + 2));
            end
            if (!weight_valid || !activation_valid) begin
                report_fail("a valid was low during a shift cycle");
            end
            shift_cnt++;
        end
    endtask

    task automatic run_bist(input logic mode, output bit done, output logic pass,
                            output lane_mask_t lanes);
        int waited;
        waited = 0;
        done   = 1'b0;
        pass   = 1'b0;
        lanes  = '0;
        wr_cnt    = 0;
        rd_cnt    = 0;
        shift_cnt = 0;
        ws_cnt    = 0;
        @(posedge clk);
        #1;
        bist_mode = mode;
        test_mode = 1'b1;
        start     = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        if (fail_lanes !== '0) begin
            report_mismatch("fail_lanes after start", 32'(fail_lanes), 32'h0);
        end
        while (!done && waited < DONE_WAIT) begin
            watch_cycle();
            if (test_done === 1'b1) begin
                done  = 1'b1;
                pass  = test_pass;
                lanes = fail_lanes;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic check_result(input bit done, input logic pass, input lane_mask_t lanes,
                                input logic exp_pass, input lane_mask_t exp_lanes);
        if (!done) begin
            report_fail("test_done did not arrive");
        end else begin
            if (pass !== exp_pass) begin
                report_mismatch("test_pass", 32'(pass), 32'(exp_pass));
            end
            if (lanes !== exp_lanes) begin
                report_mismatch("fail_lanes", 32'(lanes), 32'(exp_lanes));
            end
        end
    endtask

    task automatic test_reset_gating();
        int errs;
        logic [7:0] strobes;
        bit ran;
        errs = errors;
        ran  = 1'b0;
        @(negedge clk);
        strobes = {scan_en, acc_wr_en, acc_test_mode, weight_valid, activation_valid,
                   weight_start, test_done, test_pass};
        if (strobes !== 8'h00) begin
            report_mismatch("strobes after reset", 32'(strobes), 32'h0);
        end
        if (fail_lanes !== '0) begin
            report_mismatch("fail_lanes after reset", 32'(fail_lanes), 32'h0);
        end
        @(posedge clk);
        #1;
        test_mode = 1'b0;
        start     = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        repeat (300) begin
            @(negedge clk);
            if (test_done || acc_wr_en || scan_en) begin
                ran = 1'b1;
            end
        end
        if (ran) begin
            report_fail("start was taken while test_mode was low");
        end
        finish_test("reset_gating", errs);
    endtask

    task automatic test_mem_pass(input string name);
        int errs;
        bit done;
        logic pass;
        lane_mask_t lanes;
        errs = errors;
        run_bist(1'b0, done, pass, lanes);
        check_result(done, pass, lanes, 1'b1, '0);
        if (wr_cnt != MBIST_PATTERNS * ARRAY_SIZE) begin
            report_mismatch("write count", 32'(wr_cnt), 32'(MBIST_PATTERNS * ARRAY_SIZE));
        end
        if (rd_cnt != 2 * MBIST_PATTERNS * ARRAY_SIZE) begin
            report_mismatch("read cycle count", 32'(rd_cnt),
                            32'(2 * MBIST_PATTERNS * ARRAY_SIZE));
        end
        finish_test(name, errs);
    endtask

    task automatic test_mem_stuck(input int lane, input int bitpos);
        int errs;
        bit done;
        logic pass;
        lane_mask_t lanes;
        errs = errors;
        force_mask = psum_row_t'(1) << (lane * PSUM_W + bitpos);
        run_bist(1'b0, done, pass, lanes);
        check_result(done, pass, lanes, 1'b0, lane_mask_t'(1) << lane);
        force_mask = '0;
        finish_test("mem_stuck", errs);
    endtask

    task automatic test_scan_pass();
        int errs;
        bit done;
        logic pass;
        lane_mask_t lanes;
        errs = errors;
        run_bist(1'b1, done, pass, lanes);
        check_result(done, pass, lanes, 1'b1, '0);
        if (shift_cnt != SA_PATTERNS) begin
            report_mismatch("shift count", 32'(shift_cnt), 32'(SA_PATTERNS));
        end
        if (ws_cnt != 1) begin
            report_mismatch("weight_start pulses", 32'(ws_cnt), 32'd1);
        end
        finish_test("scan_pass", errs);
    endtask

    task automatic test_scan_fault(input int vec, input int lane);
        int errs;
        bit done;
        logic pass;
        lane_mask_t lanes;
        errs = errors;
        sa_fault_vec  = PAT_IDX_W'(vec);
        sa_fault_lane = ADDR_W'(lane);
        sa_fault_en   = 1'b1;
        run_bist(1'b1, done, pass, lanes);
        check_result(done, pass, lanes, 1'b0, lane_mask_t'(1) << lane);
        if (shift_cnt != vec + 1) begin
            report_mismatch("shift count", 32'(shift_cnt), 32'(vec + 1));
        end
        sa_fault_en = 1'b0;
        finish_test("scan_fault", errs);
    endtask

    initial begin
        int lane;
        int bitpos;
        int vec;
        void'($urandom(32'h2142));
        rst_n         = 1'b0;
        start         = 1'b0;
        test_mode     = 1'b0;
        bist_mode     = 1'b0;
        force_mask    = '0;
        sa_fault_en   = 1'b0;
        sa_fault_vec  = '0;
        sa_fault_lane = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        lane   = int'($urandom % ARRAY_SIZE);
        bitpos = int'($urandom % PSUM_W);
        test_reset_gating();
        test_mem_pass("mem_pass");
        test_mem_stuck(lane, bitpos);
        lane = int'($urandom % ARRAY_SIZE);
        vec  = int'($urandom % SA_PATTERNS);
        test_scan_pass();
        test_scan_fault(vec, lane);
        test_mem_pass("restart");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_models.sv */
// behavioural models only; the stuck bit applies to every row, the scan fault hits row 0 of one vector
`timescale 1ns/1ps
`default_nettype none

module tb_acc_model (
    input  logic                               clk,
    input  logic                               acc_wr_en,
    input  logic [bist_cfg_pkg::ADDR_W-1:0]    acc_wr_addr,
    input  bist_cfg_pkg::psum_row_t            acc_wr_data,
    input  logic [bist_cfg_pkg::ADDR_W-1:0]    acc_rd_addr,
    output bist_cfg_pkg::psum_row_t            acc_rd_data,
    input  logic                               scan_en,
    input  logic [bist_cfg_pkg::PAT_IDX_W-1:0] test_counter,
    output logic [bist_cfg_pkg::WEIGHT_W-1:0]  envm_weight,
    output logic [bist_cfg_pkg::ACT_W-1:0]     envm_activation,
    output bist_cfg_pkg::psum_t                envm_answer,
    input  bist_cfg_pkg::psum_row_t            force_mask,      // bits read back as 1
    input  logic                               sa_fault_en,
    input  logic [bist_cfg_pkg::PAT_IDX_W-1:0] sa_fault_vec,
    input  logic [bist_cfg_pkg::ADDR_W-1:0]    sa_fault_lane
);
    import bist_cfg_pkg::*;

    psum_row_t mem [ARRAY_SIZE];
    psum_row_t array_row;          // what the array leaves in row 0

    // eNVM contents for vector k
    assign envm_weight     = WEIGHT_W'(3 * test_counter + 1);
    assign envm_activation = ACT_W'(5 * test_counter + 2);
    assign envm_answer     = PSUM_W'(envm_weight) * PSUM_W'(envm_activation);

    always_comb begin
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            array_row[i] = envm_answer;
        end
        // faulty PE flips the low bit of its lane
        if (sa_fault_en && test_counter == sa_fault_vec) begin
            array_row[sa_fault_lane][0] = ~envm_answer[0];
        end
    end

    always_ff @(posedge clk) begin
        if (scan_en) begin
            mem[0] <= array_row;
        end else if (acc_wr_en) begin
            mem[acc_wr_addr] <= acc_wr_data;
        end
        acc_rd_data <= mem[acc_rd_addr] | force_mask;   // registered read
    end

endmodule

`default_nettype wire
